// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Bus widths
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 8;
    localparam int NUM_IRQ = 8;             // Timer plus seven external lines

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Address map, each block aligned to its own size
    localparam addr_t LEDS_BASE  = 16'h7FF0; // 1 byte
    localparam addr_t IRQ_BASE   = 16'h7FF2; // 2 bytes
    localparam addr_t TIMER_BASE = 16'h7FF4; // 4 bytes
    localparam addr_t MULT_BASE  = 16'h7FF8; // 8 bytes

    // Timer registers
    localparam logic [1:0] TMR_RELOAD_LO = 2'd0;
    localparam logic [1:0] TMR_RELOAD_HI = 2'd1;
    localparam logic [1:0] TMR_CTRL      = 2'd2;
    localparam logic [1:0] TMR_STATUS    = 2'd3;
    localparam int TMR_CTRL_EN   = 0;       // Count enable
    localparam int TMR_CTRL_IE   = 1;       // Interrupt enable
    localparam int TMR_STAT_FLAG = 0;       // Expiry flag

    // Multiplier registers, little endian
    localparam logic [2:0] MULT_A_LO = 3'd0;
    localparam logic [2:0] MULT_A_HI = 3'd1;
    localparam logic [2:0] MULT_B_LO = 3'd2;
    localparam logic [2:0] MULT_B_HI = 3'd3;
    localparam logic [2:0] MULT_P0   = 3'd4;
    localparam logic [2:0] MULT_P1   = 3'd5;
    localparam logic [2:0] MULT_P2   = 3'd6;
    localparam logic [2:0] MULT_P3   = 3'd7;

    // Interrupt controller registers
    localparam logic IRQ_MASK = 1'b0;
    localparam logic IRQ_PEND = 1'b1;       // Read only

endpackage

`default_nettype wire

// File: source/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  wire logic           clk_2,
    input  wire logic           i_rst_n,
    input  wire bus_pkg::addr_t i_addr,
    input  wire logic           i_sel,
    input  wire bus_pkg::data_t i_leds_data,
    input  wire bus_pkg::data_t i_irq_data,
    input  wire bus_pkg::data_t i_timer_data,
    input  wire bus_pkg::data_t i_mult_data,
    output logic                o_leds_cs,
    output logic                o_irq_cs,
    output logic                o_timer_cs,
    output logic                o_mult_cs,
    output bus_pkg::data_t      o_data
);

    logic leds_hit;
    logic irq_hit;
    logic timer_hit;
    logic mult_hit;

    // Each region is aligned, so compare only the upper bits
    assign leds_hit  = (i_addr == bus_pkg::LEDS_BASE);
    assign irq_hit   = (i_addr[bus_pkg::ADDR_W-1:1] == bus_pkg::IRQ_BASE[bus_pkg::ADDR_W-1:1]);
    assign timer_hit = (i_addr[bus_pkg::ADDR_W-1:2] == bus_pkg::TIMER_BASE[bus_pkg::ADDR_W-1:2]);
    assign mult_hit  = (i_addr[bus_pkg::ADDR_W-1:3] == bus_pkg::MULT_BASE[bus_pkg::ADDR_W-1:3]);

    assign o_leds_cs  = i_sel & leds_hit;
    assign o_irq_cs   = i_sel & irq_hit;
    assign o_timer_cs = i_sel & timer_hit;
    assign o_mult_cs  = i_sel & mult_hit;

    always_comb begin
        if (o_leds_cs) begin
            o_data = i_leds_data;
        end else if (o_irq_cs) begin
            o_data = i_irq_data;
        end else if (o_timer_cs) begin
            o_data = i_timer_data;
        end else if (o_mult_cs) begin
            o_data = i_mult_data;
        end else begin
            o_data = '0;                    // Unmapped reads as zero
        end
    end

    a_one_select: assert property (
        @(posedge clk_2) disable iff (!i_rst_n)
        $onehot0({o_leds_cs, o_irq_cs, o_timer_cs, o_mult_cs})
    ) else $error("bus_decode: more than one chip select active");

endmodule

`default_nettype wire

// File: source/board_io.sv
`timescale 1ns/1ps
`default_nettype none

module board_io #(
    parameter int RESET_HOLD = 4
) (
    input  wire logic           clk_2,
    input  wire logic           i_rst_n,
    input  wire logic           i_cs,
    input  wire logic           i_rwb,
    input  wire bus_pkg::data_t i_data,
    output bus_pkg::data_t      o_data,
    output bus_pkg::data_t      o_leds,
    output logic                o_cpu_resb
);

    localparam int CNT_W = $clog2(RESET_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            o_leds <= '0;
        end else if (i_cs && !i_rwb) begin
            o_leds <= i_data;
        end
    end

    assign o_data = o_leds;                 // LED register reads back

    // CPU reset stretcher
    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            hold_cnt   <= '0;
            o_cpu_resb <= 1'b0;
        end else if (!o_cpu_resb) begin
            if (hold_cnt == CNT_W'(RESET_HOLD - 1)) begin
                o_cpu_resb <= 1'b1;         // Release after RESET_HOLD edges
            end
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    a_resb_no_glitch: assert property (
        @(posedge clk_2)
        $fell(o_cpu_resb) |-> $past(!i_rst_n)
    ) else $error("board_io: CPU reset asserted without system reset");

endmodule

`default_nettype wire

// File: source/timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer (
    input  wire logic           clk_2,
    input  wire logic           i_rst_n,
    input  wire logic           i_cs,
    input  wire logic           i_rwb,
    input  wire logic [1:0]     i_addr,
    input  wire bus_pkg::data_t i_data,
    output bus_pkg::data_t      o_data,
    output logic                o_irq
);

    logic [15:0] reload;
    logic [15:0] count;
    logic        ctrl_en;
    logic        ctrl_ie;
    logic        flag;
    logic        expire;
    logic        wr;

    assign wr     = i_cs & ~i_rwb;
    assign expire = ctrl_en & (count == '0);

    // Register writes
    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            reload  <= '0;
            ctrl_en <= 1'b0;
            ctrl_ie <= 1'b0;
        end else if (wr) begin
            case (i_addr)
                bus_pkg::TMR_RELOAD_LO: reload[7:0]  <= i_data;
                bus_pkg::TMR_RELOAD_HI: reload[15:8] <= i_data;
                bus_pkg::TMR_CTRL: begin
                    ctrl_en <= i_data[bus_pkg::TMR_CTRL_EN];
                    ctrl_ie <= i_data[bus_pkg::TMR_CTRL_IE];
                end
                default: ;                  // Status handled below
            endcase
        end
    end

    // Down-counter, follows reload while stopped
    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (!ctrl_en || expire) begin
            count <= reload;
        end else begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            flag <= 1'b0;
        end else if (expire) begin
            flag <= 1'b1;                   // Set beats clear
        end else if (wr && i_addr == bus_pkg::TMR_STATUS) begin
            flag <= 1'b0;
        end
    end

    assign o_irq = flag & ctrl_ie;

    always_comb begin
        o_data = '0;
        case (i_addr)
            bus_pkg::TMR_RELOAD_LO: o_data = reload[7:0];
            bus_pkg::TMR_RELOAD_HI: o_data = reload[15:8];
            bus_pkg::TMR_CTRL: begin
                o_data[bus_pkg::TMR_CTRL_EN] = ctrl_en;
                o_data[bus_pkg::TMR_CTRL_IE] = ctrl_ie;
            end
            bus_pkg::TMR_STATUS: o_data[bus_pkg::TMR_STAT_FLAG] = flag;
            default: o_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module multiplier (
    input  wire logic           clk_2,
    input  wire logic           i_rst_n,
    input  wire logic           i_cs,
    input  wire logic           i_rwb,
    input  wire logic [2:0]     i_addr,
    input  wire bus_pkg::data_t i_data,
    output bus_pkg::data_t      o_data
);

    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [31:0] product;

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else if (i_cs && !i_rwb) begin
            case (i_addr)
                bus_pkg::MULT_A_LO: op_a[7:0]  <= i_data;
                bus_pkg::MULT_A_HI: op_a[15:8] <= i_data;
                bus_pkg::MULT_B_LO: op_b[7:0]  <= i_data;
                bus_pkg::MULT_B_HI: op_b[15:8] <= i_data;
                default: ;                  // Product is read only
            endcase
        end
    end

    always_ff @(posedge clk_2) begin
        product <= op_a * op_b;             // Unsigned, one cycle behind operands
    end

    always_comb begin
        case (i_addr)
            bus_pkg::MULT_A_LO: o_data = op_a[7:0];
            bus_pkg::MULT_A_HI: o_data = op_a[15:8];
            bus_pkg::MULT_B_LO: o_data = op_b[7:0];
            bus_pkg::MULT_B_HI: o_data = op_b[15:8];
            bus_pkg::MULT_P0:   o_data = product[7:0];
            bus_pkg::MULT_P1:   o_data = product[15:8];
            bus_pkg::MULT_P2:   o_data = product[23:16];
            bus_pkg::MULT_P3:   o_data = product[31:24];
            default:            o_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller #(
    parameter int NUM_SRC = 8
) (
    input  wire logic               clk_2,
    input  wire logic               i_rst_n,
    input  wire logic               i_cs,
    input  wire logic               i_rwb,
    input  wire logic               i_addr,
    input  wire bus_pkg::data_t     i_data,
    input  wire logic [NUM_SRC-1:0] i_src,
    output bus_pkg::data_t          o_data,
    output logic                    o_cpu_irqb
);

    logic [NUM_SRC-1:0] mask;
    logic [NUM_SRC-1:0] pend;

    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            mask <= '0;
        end else if (i_cs && !i_rwb && i_addr == bus_pkg::IRQ_MASK) begin
            mask <= i_data[NUM_SRC-1:0];
        end
    end

    // Level sampled, no latching
    always_ff @(posedge clk_2) begin
        if (!i_rst_n) begin
            pend <= '0;
        end else begin
            pend <= i_src;
        end
    end

    assign o_cpu_irqb = ~|(pend & mask);

    always_comb begin
        if (i_addr == bus_pkg::IRQ_PEND) begin
            o_data = bus_pkg::DATA_W'(pend);
        end else begin
            o_data = bus_pkg::DATA_W'(mask);
        end
    end

    // IRQ only follows a masked-in source seen on the previous edge
    a_irq_needs_source: assert property (
        @(posedge clk_2) disable iff (!i_rst_n)
        !o_cpu_irqb |-> |($past(i_src) & mask)
    ) else $error("interrupt_controller: IRQ asserted without an enabled source");

endmodule

`default_nettype wire

// File: source/super6502_io.sv
`timescale 1ns/1ps
`default_nettype none

module super6502_io #(
    parameter int RESET_HOLD = 4
) (
    input  wire logic                        clk_2,
    input  wire logic                        i_rst_n,
    input  wire logic                        i_cpu_sel,
    input  wire logic                        i_cpu_rwb,
    input  wire bus_pkg::addr_t              i_cpu_addr,
    input  wire bus_pkg::data_t              i_cpu_data,
    input  wire logic [bus_pkg::NUM_IRQ-2:0] i_ext_irqb,
    output bus_pkg::data_t                   o_cpu_data,
    output logic                             o_cpu_irqb,
    output logic                             o_cpu_resb,
    output bus_pkg::data_t                   o_leds
);

    logic leds_cs;
    logic irq_cs;
    logic timer_cs;
    logic mult_cs;
    logic timer_irq;

    bus_pkg::data_t leds_data;
    bus_pkg::data_t irq_data;
    bus_pkg::data_t timer_data;
    bus_pkg::data_t mult_data;

    logic [bus_pkg::NUM_IRQ-1:0] irq_src;

    assign irq_src = {~i_ext_irqb, timer_irq}; // Source 0 is the timer

    bus_decode u_bus_decode (
        .clk_2        (clk_2),
        .i_rst_n      (i_rst_n),
        .i_addr       (i_cpu_addr),
        .i_sel        (i_cpu_sel),
        .i_leds_data  (leds_data),
        .i_irq_data   (irq_data),
        .i_timer_data (timer_data),
        .i_mult_data  (mult_data),
        .o_leds_cs    (leds_cs),
        .o_irq_cs     (irq_cs),
        .o_timer_cs   (timer_cs),
        .o_mult_cs    (mult_cs),
        .o_data       (o_cpu_data)
    );

    board_io #(
        .RESET_HOLD (RESET_HOLD)
    ) u_board_io (
        .clk_2      (clk_2),
        .i_rst_n    (i_rst_n),
        .i_cs       (leds_cs),
        .i_rwb      (i_cpu_rwb),
        .i_data     (i_cpu_data),
        .o_data     (leds_data),
        .o_leds     (o_leds),
        .o_cpu_resb (o_cpu_resb)
    );

    timer u_timer (
        .clk_2   (clk_2),
        .i_rst_n (i_rst_n),
        .i_cs    (timer_cs),
        .i_rwb   (i_cpu_rwb),
        .i_addr  (i_cpu_addr[1:0]),
        .i_data  (i_cpu_data),
        .o_data  (timer_data),
        .o_irq   (timer_irq)
    );

    multiplier u_multiplier (
        .clk_2   (clk_2),
        .i_rst_n (i_rst_n),
        .i_cs    (mult_cs),
        .i_rwb   (i_cpu_rwb),
        .i_addr  (i_cpu_addr[2:0]),
        .i_data  (i_cpu_data),
        .o_data  (mult_data)
    );

    interrupt_controller #(
        .NUM_SRC (bus_pkg::NUM_IRQ)
    ) u_interrupt_controller (
        .clk_2      (clk_2),
        .i_rst_n    (i_rst_n),
        .i_cs       (irq_cs),
        .i_rwb      (i_cpu_rwb),
        .i_addr     (i_cpu_addr[0]),
        .i_data     (i_cpu_data),
        .i_src      (irq_src),
        .o_data     (irq_data),
        .o_cpu_irqb (o_cpu_irqb)
    );

endmodule

`default_nettype wire

// File: tb/tb_super6502_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_super6502_io;

    localparam int RESET_HOLD     = 4;
    localparam int CLK_HALF       = 20;
    localparam int TIMEOUT_CYCLES = 2000;  // Full run takes roughly 450 cycles
    localparam int TMR_RELOAD     = 10;
    localparam int MULT_PAIRS     = 20;

    logic                            clk_2 = 1'b0;
    logic                            i_rst_n;
    logic                            i_cpu_sel;
    logic                            i_cpu_rwb;
    bus_pkg::addr_t                  i_cpu_addr;
    bus_pkg::data_t                  i_cpu_data;
    logic [bus_pkg::NUM_IRQ-2:0]     i_ext_irqb;
    bus_pkg::data_t                  o_cpu_data;
    logic                            o_cpu_irqb;
    logic                            o_cpu_resb;
    bus_pkg::data_t                  o_leds;

    int          cycle_count  = 0;
    int          check_count  = 0;
    int          error_count  = 0;
    int          test_errors  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic [31:0] rng_state    = 32'h1528_d11a;

    super6502_io #(
        .RESET_HOLD (RESET_HOLD)
    ) u_super6502_io (
        .clk_2      (clk_2),
        .i_rst_n    (i_rst_n),
        .i_cpu_sel  (i_cpu_sel),
        .i_cpu_rwb  (i_cpu_rwb),
        .i_cpu_addr (i_cpu_addr),
        .i_cpu_data (i_cpu_data),
        .i_ext_irqb (i_ext_irqb),
        .o_cpu_data (o_cpu_data),
        .o_cpu_irqb (o_cpu_irqb),
        .o_cpu_resb (o_cpu_resb),
        .o_leds     (o_leds)
    );

    always #CLK_HALF clk_2 = ~clk_2;

    always @(posedge clk_2) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bus_pkg::addr_t timer_addr(input logic [1:0] off);
        return bus_pkg::TIMER_BASE + 16'(off);
    endfunction

    function automatic bus_pkg::addr_t mult_addr(input logic [2:0] off);
        return bus_pkg::MULT_BASE + 16'(off);
    endfunction

    function automatic bus_pkg::addr_t irq_addr(input logic off);
        return bus_pkg::IRQ_BASE + 16'(off);
    endfunction

    task automatic note_error(input string msg);
        if (msg != "") begin
            $display("%s", msg);
        end
        test_errors++;
        error_count++;
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t expected,
                              input bus_pkg::data_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
            note_error("");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            note_error("");
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_2);
    endtask

    // Write is taken on the second edge, bus is idle afterwards
    task automatic bus_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data);
        @(posedge clk_2);
        i_cpu_sel  <= 1'b1;
        i_cpu_rwb  <= 1'b0;
        i_cpu_addr <= addr;
        i_cpu_data <= data;
        @(posedge clk_2);
        i_cpu_sel  <= 1'b0;
        i_cpu_rwb  <= 1'b1;
    endtask

    task automatic bus_read(input bus_pkg::addr_t addr, output bus_pkg::data_t data);
        @(posedge clk_2);
        i_cpu_sel  <= 1'b1;
        i_cpu_rwb  <= 1'b1;
        i_cpu_addr <= addr;
        @(negedge clk_2);
        data = o_cpu_data;                 // Mid-cycle, data is settled
    endtask

    task automatic read_check(input string name, input bus_pkg::addr_t addr,
                              input bus_pkg::data_t expected);
        bus_pkg::data_t d;
        bus_read(addr, d);
        check_data(name, expected, d);
    endtask

    task automatic test_reset();
        repeat (4) @(posedge clk_2);
        @(negedge clk_2);
        check_bit("reset irqb", 1'b1, o_cpu_irqb);
        check_data("reset leds", 8'h00, o_leds);
        check_bit("reset resb held", 1'b0, o_cpu_resb);
        @(posedge clk_2);
        i_rst_n <= 1'b1;
        for (int k = 0; k <= RESET_HOLD; k++) begin
            @(negedge clk_2);
            check_bit("reset resb release", logic'(k >= RESET_HOLD), o_cpu_resb);
            if (k < RESET_HOLD) begin
                @(posedge clk_2);
            end
        end
        check_bit("reset irqb after", 1'b1, o_cpu_irqb);
        finish_test("reset");
    endtask

    task automatic test_leds();
        bus_write(bus_pkg::LEDS_BASE, 8'hA5);
        @(negedge clk_2);
        check_data("leds output", 8'hA5, o_leds);
        read_check("leds readback", bus_pkg::LEDS_BASE, 8'hA5);
        bus_write(bus_pkg::LEDS_BASE, 8'h3C);
        @(negedge clk_2);
        check_data("leds output 2", 8'h3C, o_leds);
        read_check("leds readback 2", bus_pkg::LEDS_BASE, 8'h3C);
        read_check("unmapped low", 16'h1234, 8'h00);
        read_check("unmapped gap", 16'h7FF1, 8'h00);  // Between LEDs and IRQ
        finish_test("leds");
    endtask

    task automatic test_multiplier();
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] expected;
        for (int n = 0; n < MULT_PAIRS; n++) begin
            rng_state = xorshift32(rng_state);
            a = rng_state[15:0];
            b = rng_state[31:16];
            expected = {16'h0000, a} * {16'h0000, b};
            bus_write(mult_addr(bus_pkg::MULT_A_LO), a[7:0]);
            bus_write(mult_addr(bus_pkg::MULT_A_HI), a[15:8]);
            bus_write(mult_addr(bus_pkg::MULT_B_LO), b[7:0]);
            bus_write(mult_addr(bus_pkg::MULT_B_HI), b[15:8]);
            for (int i = 0; i < 4; i++) begin
                read_check("mult product", mult_addr(bus_pkg::MULT_P0 + 3'(i)),
                           expected[8*i +: 8]);
            end
        end
        // Product bytes must ignore writes
        for (int i = 0; i < 4; i++) begin
            bus_write(mult_addr(bus_pkg::MULT_P0 + 3'(i)), 8'hFF);
        end
        for (int i = 0; i < 4; i++) begin
            read_check("mult product after write", mult_addr(bus_pkg::MULT_P0 + 3'(i)),
                       expected[8*i +: 8]);
        end
        read_check("mult operand a", mult_addr(bus_pkg::MULT_A_LO), a[7:0]);
        finish_test("multiplier");
    endtask

    task automatic test_timer();
        bus_write(timer_addr(bus_pkg::TMR_RELOAD_LO), 8'(TMR_RELOAD));
        bus_write(timer_addr(bus_pkg::TMR_RELOAD_HI), 8'h00);
        bus_write(timer_addr(bus_pkg::TMR_CTRL), 8'h01);   // Enable only
        idle_cycles(TMR_RELOAD - 1);
        read_check("timer flag at R", timer_addr(bus_pkg::TMR_STATUS), 8'h00);
        idle_cycles(1);
        read_check("timer flag at R+2", timer_addr(bus_pkg::TMR_STATUS), 8'h01);
        bus_write(timer_addr(bus_pkg::TMR_CTRL), 8'h00);
        read_check("timer flag held", timer_addr(bus_pkg::TMR_STATUS), 8'h01);
        bus_write(timer_addr(bus_pkg::TMR_STATUS), 8'h00);
        read_check("timer flag cleared", timer_addr(bus_pkg::TMR_STATUS), 8'h00);
        read_check("timer reload lo", timer_addr(bus_pkg::TMR_RELOAD_LO), 8'(TMR_RELOAD));
        finish_test("timer");
    endtask

    task automatic test_interrupts();
        bus_pkg::data_t d;
        logic           seen;
        seen = 1'b0;
        bus_write(timer_addr(bus_pkg::TMR_RELOAD_LO), 8'd5);
        bus_write(timer_addr(bus_pkg::TMR_CTRL), 8'h03);   // Enable and IE
        for (int n = 0; n < 20 && !seen; n++) begin
            bus_read(timer_addr(bus_pkg::TMR_STATUS), d);
            seen = d[bus_pkg::TMR_STAT_FLAG];
        end
        if (!seen) begin
            note_error("timer expiry flag did not set within 20 reads");
        end
        idle_cycles(2);
        @(negedge clk_2);
        check_bit("irqb with mask zero", 1'b1, o_cpu_irqb);
        bus_write(irq_addr(bus_pkg::IRQ_MASK), 8'h01);
        @(negedge clk_2);
        check_bit("irqb timer masked in", 1'b0, o_cpu_irqb);
        read_check("irq pend timer", irq_addr(bus_pkg::IRQ_PEND), 8'h01);
        bus_write(timer_addr(bus_pkg::TMR_CTRL), 8'h00);
        bus_write(timer_addr(bus_pkg::TMR_STATUS), 8'h00);
        idle_cycles(1);
        @(negedge clk_2);
        check_bit("irqb timer cleared", 1'b1, o_cpu_irqb);

        // External line 3 is source 4
        bus_write(irq_addr(bus_pkg::IRQ_MASK), 8'h10);
        @(posedge clk_2);
        i_ext_irqb[3] <= 1'b0;
        @(negedge clk_2);
        check_bit("irqb ext before sample", 1'b1, o_cpu_irqb);
        @(posedge clk_2);
        @(negedge clk_2);
        check_bit("irqb ext active", 1'b0, o_cpu_irqb);
        read_check("irq pend ext", irq_addr(bus_pkg::IRQ_PEND), 8'h10);
        read_check("irq mask readback", irq_addr(bus_pkg::IRQ_MASK), 8'h10);
        @(posedge clk_2);
        i_ext_irqb[3] <= 1'b1;
        @(negedge clk_2);
        check_bit("irqb ext release pending", 1'b0, o_cpu_irqb);
        @(posedge clk_2);
        @(negedge clk_2);
        check_bit("irqb ext released", 1'b1, o_cpu_irqb);
        finish_test("interrupts");
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_cpu_sel  = 1'b0;
        i_cpu_rwb  = 1'b1;
        i_cpu_addr = '0;
        i_cpu_data = '0;
        i_ext_irqb = '1;                   // All external lines idle

        test_reset();
        test_leds();
        test_multiplier();
        test_timer();
        test_interrupts();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/bus_pkg.sv
source/bus_decode.sv
source/board_io.sv
source/timer.sv
source/multiplier.sv
source/interrupt_controller.sv
source/super6502_io.sv
tb/tb_super6502_io.sv

// File: run.sh
#!/bin/sh
# Build and run the super6502_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_super6502_io \
    -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0
